// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_access
FILELIST  = vlog.f

.PHONY: sim clean

# Build and run, status decided by the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "PASS: all tests"

clean:
	rm -rf obj_dir

// ==== data_ram.sv ====
`include "mem_macros.svh"

module data_ram (
    input  logic           clk,
    input  logic           accept_i,
    ram_port_if.wr_dst     wr,
    output mem_pkg::word_t rdata_o
);

    import mem_pkg::*;

    word_t mem [`MEM_DEPTH];

    ////////////////////
    // Byte lane writes and read-first port
    ////////////////////

    always_ff @(posedge clk) begin
        if (wr.we) begin
            for (int b = 0; b < `MEM_BE_W; b++) begin
                if (wr.be[b]) begin
                    mem[wr.idx][8*b +: 8] <= wr.wdata[8*b +: 8];
                end
            end
        end
        // Old contents are read, held until the next accept
        if (accept_i) begin
            rdata_o <= mem[wr.idx];
        end
    end

endmodule

// ==== load_align.sv ====
module load_align (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             accept_i,
    input  mem_pkg::mem_op_e op_i,
    input  mem_pkg::word_t   addr_i,
    input  mem_pkg::word_t   ram_rdata_i,
    output mem_pkg::word_t   rdata_o,
    output logic             adel_o
);

    import mem_pkg::*;

    mem_op_e     op_q;
    logic [1:0]  off_q;
    logic        adel_d;
    logic        adel_q;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Misaligned LW, or LH/LHU on an odd byte
    assign adel_d = ((op_i == OP_LW) && (addr_i[1:0] != 2'b00)) ||
                    (((op_i == OP_LH) || (op_i == OP_LHU)) && addr_i[0]);

    ////////////////////
    // Capture at accept
    ////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            op_q   <= OP_SW;  // Store opcode gives zero data
            adel_q <= 1'b0;
        end else if (accept_i) begin
            op_q   <= op_i;
            adel_q <= adel_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            off_q <= addr_i[1:0];
        end
    end

    ////////////////////
    // Lane select and extend
    ////////////////////

    assign byte_sel = ram_rdata_i[8*off_q +: 8];
    assign half_sel = off_q[1] ? ram_rdata_i[31:16] : ram_rdata_i[15:0];

    always_comb begin
        case (op_q)
            OP_LW:   rdata_o = ram_rdata_i;
            OP_LH:   rdata_o = {{16{half_sel[15]}}, half_sel};
            OP_LHU:  rdata_o = {16'b0, half_sel};
            OP_LB:   rdata_o = {{24{byte_sel[7]}}, byte_sel};
            OP_LBU:  rdata_o = {24'b0, byte_sel};
            default: rdata_o = '0;          // Stores return nothing
        endcase
        if (adel_q) begin
            rdata_o = '0;                   // Faulting load
        end
    end

    assign adel_o = adel_q;

    // A raised load error always sits with a held misaligned load, never a store
    a_adel_misaligned_load : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        adel_o |-> ((op_q == OP_LW) && (off_q != 2'b00)) ||
                   (((op_q == OP_LH) || (op_q == OP_LHU)) && off_q[0])
    );

endmodule

// ==== mem_access_top.sv ====
module mem_access_top (
    input  logic               clk,
    input  logic               rst_n_i,
    // Request
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  mem_pkg::mem_op_e   req_op_i,
    input  mem_pkg::word_t     req_addr_i,
    input  mem_pkg::word_t     req_wdata_i,
    // Response
    output logic               resp_valid_o,
    input  logic               resp_ready_i,
    output mem_pkg::word_t     resp_rdata_o,
    output mem_pkg::exc_code_e resp_exc_o,
    output mem_pkg::word_t     resp_bad_addr_o
);

    import mem_pkg::*;

    logic  accept;
    logic  ades;
    logic  adel;
    word_t ram_rdata;
    word_t load_rdata;

    ram_port_if ram_wr ();

    ////////////////////
    // Store and load paths
    ////////////////////

    store_align u_store_align (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .accept_i (accept),
        .op_i     (req_op_i),
        .addr_i   (req_addr_i),
        .wdata_i  (req_wdata_i),
        .wr       (ram_wr.wr_src),
        .ades_o   (ades)
    );

    data_ram u_data_ram (
        .clk      (clk),
        .accept_i (accept),
        .wr       (ram_wr.wr_dst),
        .rdata_o  (ram_rdata)
    );

    load_align u_load_align (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .accept_i    (accept),
        .op_i        (req_op_i),
        .addr_i      (req_addr_i),
        .ram_rdata_i (ram_rdata),
        .rdata_o     (load_rdata),
        .adel_o      (adel)
    );

    // Response slot, owns the handshake
    resp_merge u_resp_merge (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .accept_o        (accept),
        .addr_i          (req_addr_i),
        .ades_i          (ades),
        .adel_i          (adel),
        .load_rdata_i    (load_rdata),
        .resp_valid_o    (resp_valid_o),
        .resp_ready_i    (resp_ready_i),
        .resp_rdata_o    (resp_rdata_o),
        .resp_exc_o      (resp_exc_o),
        .resp_bad_addr_o (resp_bad_addr_o)
    );

endmodule

// ==== mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

////////////////////
// Data path geometry
////////////////////

// Word width in bits
`define MEM_DATA_W 32

// Byte lanes per word
`define MEM_BE_W 4

////////////////////
// RAM sizing
////////////////////

// Words in the data RAM
`define MEM_DEPTH 64

// Word index, taken from byte address bits 7..2
`define MEM_IDX_W 6

`endif

// ==== mem_pkg.sv ====
`include "mem_macros.svh"

package mem_pkg;

    // Memory opcodes seen by the MEM stage
    typedef enum logic [2:0] {
        OP_LW  = 3'd0,
        OP_LH  = 3'd1,
        OP_LHU = 3'd2,
        OP_LB  = 3'd3,
        OP_LBU = 3'd4,
        OP_SW  = 3'd5,
        OP_SH  = 3'd6,
        OP_SB  = 3'd7
    } mem_op_e;

    // MIPS cause register ExcCode values
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,  // Address error on load
        EXC_ADES = 5'd5   // Address error on store
    } exc_code_e;

    typedef logic [`MEM_DATA_W-1:0] word_t;

endpackage

// ==== ram_port_if.sv ====
`include "mem_macros.svh"

interface ram_port_if;

    logic                   we;     // Write strobe, already qualified by accept
    logic [`MEM_BE_W-1:0]   be;     // Lane enables
    logic [`MEM_IDX_W-1:0]  idx;    // Word index, also used for the read
    logic [`MEM_DATA_W-1:0] wdata;  // Lane-replicated store data

    // Store side
    modport wr_src (
        output we,
        output be,
        output idx,
        output wdata
    );

    // RAM side
    modport wr_dst (
        input we,
        input be,
        input idx,
        input wdata
    );

endinterface

// ==== resp_merge.sv ====
module resp_merge (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    output logic               accept_o,
    input  mem_pkg::word_t     addr_i,
    input  logic               ades_i,
    input  logic               adel_i,
    input  mem_pkg::word_t     load_rdata_i,
    output logic               resp_valid_o,
    input  logic               resp_ready_i,
    output mem_pkg::word_t     resp_rdata_o,
    output mem_pkg::exc_code_e resp_exc_o,
    output mem_pkg::word_t     resp_bad_addr_o
);

    import mem_pkg::*;

    logic  valid_q;
    logic  ades_q;
    word_t addr_q;

    ////////////////////
    // Slot and accept
    ////////////////////

    assign req_ready_o = !valid_q || resp_ready_i;  // Empty, or draining now
    assign accept_o    = req_valid_i && req_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            ades_q  <= 1'b0;
        end else if (accept_o) begin
            valid_q <= 1'b1;
            ades_q  <= ades_i;
        end else if (resp_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_o) begin
            addr_q <= addr_i;
        end
    end

    ////////////////////
    // Response payload
    ////////////////////

    assign resp_valid_o    = valid_q;
    assign resp_rdata_o    = load_rdata_i;   // Already zero on stores and faults
    assign resp_exc_o      = adel_i ? EXC_ADEL :
                             ades_q ? EXC_ADES : EXC_NONE;
    assign resp_bad_addr_o = (adel_i || ades_q) ? addr_q : '0;

    // Payload comes from three modules and must hold while the consumer stalls
    a_resp_stable : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        resp_valid_o && !resp_ready_i |=>
            resp_valid_o && $stable(resp_rdata_o) && $stable(resp_exc_o) &&
            $stable(resp_bad_addr_o)
    );

endmodule

// ==== store_align.sv ====
`include "mem_macros.svh"

module store_align (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            accept_i,
    input  mem_pkg::mem_op_e op_i,
    input  mem_pkg::word_t  addr_i,
    input  mem_pkg::word_t  wdata_i,
    ram_port_if.wr_src      wr,
    output logic            ades_o
);

    import mem_pkg::*;

    logic [`MEM_BE_W-1:0] be_d;
    word_t                wdata_d;

    ////////////////////
    // Lane replication and byte mask
    ////////////////////

    always_comb begin
        be_d    = '0;
        wdata_d = wdata_i;
        ades_o  = 1'b0;
        case (op_i)
            OP_SW: begin
                if (addr_i[1:0] != 2'b00) begin
                    ades_o = 1'b1;      // Word store must be aligned
                end else begin
                    be_d = '1;
                end
            end
            OP_SH: begin
                wdata_d = {2{wdata_i[15:0]}};
                if (addr_i[0]) begin
                    ades_o = 1'b1;      // Odd halfword address
                end else begin
                    be_d = addr_i[1] ? 4'b1100 : 4'b0011;
                end
            end
            OP_SB: begin
                wdata_d            = {4{wdata_i[7:0]}};
                be_d[addr_i[1:0]]  = 1'b1;  // One lane, never faults
            end
            default: ;                      // Loads write nothing
        endcase
    end

    assign wr.be    = be_d;
    assign wr.wdata = wdata_d;
    assign wr.idx   = addr_i[`MEM_IDX_W+1:2];  // Upper address bits wrap
    assign wr.we    = accept_i && (be_d != '0);

    // A write lands only at accept, from a store, on as many lanes as the store is wide
    a_we_needs_accept : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wr.we |-> accept_i && (op_i inside {OP_SW, OP_SH, OP_SB}) &&
                  ($countones(wr.be) ==
                   ((op_i == OP_SW) ? 4 : (op_i == OP_SH) ? 2 : 1))
    );

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD = 10
) (
    output logic clk_o
);

    // Free-running clock, low at time zero
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

// ==== tb_mem_access.sv ====
module tb_mem_access;

    import mem_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int PASSES       = 2;    // Ready held high, then random back-pressure

    logic      clk;
    logic      rst_n_i;
    logic      req_valid_i;
    logic      req_ready_o;
    mem_op_e   req_op_i;
    word_t     req_addr_i;
    word_t     req_wdata_i;
    logic      resp_valid_o;
    logic      resp_ready_i;
    word_t     resp_rdata_o;
    exc_code_e resp_exc_o;
    word_t     resp_bad_addr_o;

    // Stimulus and expected response, one entry per request
    mem_op_e   tab_op [$];
    word_t     tab_addr [$];
    word_t     tab_wdata [$];
    word_t     tab_rdata [$];
    exc_code_e tab_exc [$];
    word_t     tab_bad [$];

    integer    seed          = 80715;
    int        total_reqs    = 0;
    int        timeout_limit = 0;
    int        cycle_count   = 0;
    int        accept_count  = 0;
    int        resp_count    = 0;
    int        idx;
    logic      accepted_last = 1'b0;
    logic      stalled_last  = 1'b0;
    word_t     held_rdata;
    exc_code_e held_exc;
    word_t     held_bad;

    tb_clk_gen #(.PERIOD(10)) u_clk_gen (.clk_o(clk));

    mem_access_top UUT (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_op_i        (req_op_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .resp_valid_o    (resp_valid_o),
        .resp_ready_i    (resp_ready_i),
        .resp_rdata_o    (resp_rdata_o),
        .resp_exc_o      (resp_exc_o),
        .resp_bad_addr_o (resp_bad_addr_o)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic add_entry(input mem_op_e op, input word_t addr, input word_t wdata,
                             input word_t rdata, input exc_code_e exc, input word_t bad);
        tab_op.push_back(op);
        tab_addr.push_back(addr);
        tab_wdata.push_back(wdata);
        tab_rdata.push_back(rdata);
        tab_exc.push_back(exc);
        tab_bad.push_back(bad);
    endtask

    ////////////////////
    // Request table
    ////////////////////

    task automatic build_table();
        add_entry(OP_SW,  32'h10, 32'h8196a5c3, 32'h0,        EXC_NONE, 32'h0);
        add_entry(OP_LW,  32'h10, 32'h0,        32'h8196a5c3, EXC_NONE, 32'h0);
        add_entry(OP_LH,  32'h10, 32'h0,        32'hffffa5c3, EXC_NONE, 32'h0);
        add_entry(OP_LH,  32'h12, 32'h0,        32'hffff8196, EXC_NONE, 32'h0);
        add_entry(OP_LHU, 32'h10, 32'h0,        32'h0000a5c3, EXC_NONE, 32'h0);
        add_entry(OP_LHU, 32'h12, 32'h0,        32'h00008196, EXC_NONE, 32'h0);
        add_entry(OP_LB,  32'h10, 32'h0,        32'hffffffc3, EXC_NONE, 32'h0);
        add_entry(OP_LB,  32'h11, 32'h0,        32'hffffffa5, EXC_NONE, 32'h0);
        add_entry(OP_LB,  32'h12, 32'h0,        32'hffffff96, EXC_NONE, 32'h0);
        add_entry(OP_LB,  32'h13, 32'h0,        32'hffffff81, EXC_NONE, 32'h0);
        add_entry(OP_LBU, 32'h10, 32'h0,        32'h000000c3, EXC_NONE, 32'h0);
        add_entry(OP_LBU, 32'h11, 32'h0,        32'h000000a5, EXC_NONE, 32'h0);
        add_entry(OP_LBU, 32'h12, 32'h0,        32'h00000096, EXC_NONE, 32'h0);
        add_entry(OP_LBU, 32'h13, 32'h0,        32'h00000081, EXC_NONE, 32'h0);
        // Positive lanes, no sign fill
        add_entry(OP_SW,  32'h24, 32'h7f3c4e12, 32'h0,        EXC_NONE, 32'h0);
        add_entry(OP_LH,  32'h24, 32'h0,        32'h00004e12, EXC_NONE, 32'h0);
        add_entry(OP_LH,  32'h26, 32'h0,        32'h00007f3c, EXC_NONE, 32'h0);
        add_entry(OP_LB,  32'h25, 32'h0,        32'h0000004e, EXC_NONE, 32'h0);
        add_entry(OP_LB,  32'h27, 32'h0,        32'h0000007f, EXC_NONE, 32'h0);
        // Partial stores, other lanes kept
        add_entry(OP_SH,  32'h12, 32'h1234beef, 32'h0,        EXC_NONE, 32'h0);
        add_entry(OP_LW,  32'h10, 32'h0,        32'hbeefa5c3, EXC_NONE, 32'h0);
        add_entry(OP_SB,  32'h11, 32'h0000005a, 32'h0,        EXC_NONE, 32'h0);
        add_entry(OP_LW,  32'h10, 32'h0,        32'hbeef5ac3, EXC_NONE, 32'h0);
        add_entry(OP_SH,  32'h10, 32'hffff7e01, 32'h0,        EXC_NONE, 32'h0);
        add_entry(OP_LW,  32'h10, 32'h0,        32'hbeef7e01, EXC_NONE, 32'h0);
        add_entry(OP_SB,  32'h13, 32'hffffffc0, 32'h0,        EXC_NONE, 32'h0);
        add_entry(OP_LW,  32'h10, 32'h0,        32'hc0ef7e01, EXC_NONE, 32'h0);
        add_entry(OP_LW,  32'h24, 32'h0,        32'h7f3c4e12, EXC_NONE, 32'h0);
        // Address errors
        add_entry(OP_LW,  32'h11, 32'h0,        32'h0,        EXC_ADEL, 32'h11);
        add_entry(OP_LW,  32'h13, 32'h0,        32'h0,        EXC_ADEL, 32'h13);
        add_entry(OP_LH,  32'h13, 32'h0,        32'h0,        EXC_ADEL, 32'h13);
        add_entry(OP_LHU, 32'h11, 32'h0,        32'h0,        EXC_ADEL, 32'h11);
        add_entry(OP_SW,  32'h12, 32'hdeadbeef, 32'h0,        EXC_ADES, 32'h12);
        add_entry(OP_SH,  32'h11, 32'h0000ffff, 32'h0,        EXC_ADES, 32'h11);
        add_entry(OP_SW,  32'h11, 32'h55555555, 32'h0,        EXC_ADES, 32'h11);
        add_entry(OP_LW,  32'h10, 32'h0,        32'hc0ef7e01, EXC_NONE, 32'h0);  // Untouched
    endtask

    ////////////////////
    // Request driver
    ////////////////////

    initial begin
        rst_n_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_op_i     = OP_LW;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        build_table();
        total_reqs    = PASSES * tab_op.size();
        timeout_limit = RESET_CYCLES + 20 * total_reqs + 50;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        check_value("resp_valid_o", 32'(resp_valid_o), 32'h0);
        check_value("req_ready_o", 32'(req_ready_o), 32'h1);

        for (int p = 0; p < PASSES; p++) begin
            foreach (tab_op[i]) begin
                req_valid_i = 1'b1;
                req_op_i    = tab_op[i];
                req_addr_i  = tab_addr[i];
                req_wdata_i = tab_wdata[i];
                @(posedge clk);
                if (p == 0) begin
                    // No back-pressure yet, so one accept per cycle
                    check_value("req_ready_o", 32'(req_ready_o), 32'h1);
                end
                while (!req_ready_o) @(posedge clk);
                @(negedge clk);
            end
        end
        req_valid_i = 1'b0;

        wait (resp_count == total_reqs);
        repeat (3) @(negedge clk);
        check_value("resp_valid_o", 32'(resp_valid_o), 32'h0);  // No extra response

        if (accept_count == total_reqs && resp_count == total_reqs) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Request and response counts differ: %0d accepted, %0d answered",
                     accept_count, resp_count);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    // Consumer stalls at random once the first pass has drained
    initial begin
        resp_ready_i = 1'b1;
        forever begin
            @(negedge clk);
            if (resp_count >= tab_op.size()) begin
                resp_ready_i = (($random(seed) & 1) != 0);
            end else begin
                resp_ready_i = 1'b1;
            end
        end
    end

    ////////////////////
    // Response monitor
    ////////////////////

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("FAIL: see errors above");
            $fatal(1);
        end
        if (rst_n_i) begin
            if (accepted_last) begin
                check_value("resp_valid_o", 32'(resp_valid_o), 32'h1);  // One cycle latency
            end
            if (stalled_last) begin
                check_value("resp_valid_o", 32'(resp_valid_o), 32'h1);
                check_value("resp_rdata_o", resp_rdata_o, held_rdata);
                check_value("resp_exc_o", 32'(resp_exc_o), 32'(held_exc));
                check_value("resp_bad_addr_o", resp_bad_addr_o, held_bad);
            end
            accepted_last = req_valid_i && req_ready_o;
            stalled_last  = resp_valid_o && !resp_ready_i;
            held_rdata    = resp_rdata_o;
            held_exc      = resp_exc_o;
            held_bad      = resp_bad_addr_o;

            if (resp_valid_o && resp_ready_i) begin
                if (resp_count >= accept_count) begin
                    $display("Response seen with no request outstanding");
                    $display("FAIL: see errors above");
                    $fatal(1);
                end
                idx = resp_count % tab_op.size();
                check_value("resp_rdata_o", resp_rdata_o, tab_rdata[idx]);
                check_value("resp_exc_o", 32'(resp_exc_o), 32'(tab_exc[idx]));
                check_value("resp_bad_addr_o", resp_bad_addr_o, tab_bad[idx]);
                resp_count = resp_count + 1;
            end
            if (accepted_last) begin
                accept_count = accept_count + 1;
            end
        end
    end

endmodule

// ==== vlog.f ====
+incdir+.
mem_pkg.sv
ram_port_if.sv
store_align.sv
load_align.sv
data_ram.sv
resp_merge.sv
mem_access_top.sv
tb_clk_gen.sv
tb_mem_access.sv
